//--- fc_defines.svh
`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

// Network sizes, all multiples of the lane count
`define FC_N_IN      16
`define FC_N_HID     4
`define FC_N_OUT     4

// Word and lane geometry
`define FC_LANES     4
`define FC_WORD_W    32

// RAM address widths
`define FC_FEAT_AW   4
`define FC_PARAM_AW  6

// Datapath widths and requantization
`define FC_ACC_W     24
`define FC_SHIFT     6
`define FC_CLASS_W   2

// Feature RAM map, in words
`define FC_IN_BASE   0
`define FC_HID_BASE  8

// Parameter RAM map, in words
`define FC_W0_BASE   0
`define FC_B0_BASE   16
`define FC_W1_BASE   20
`define FC_B1_BASE   24

`endif

//--- fc_pkg.sv
`default_nettype none
`include "fc_defines.svh"

package fc_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        MAC,
        BIAS,
        STORE,
        DONE
    } fc_state_e;

    // Load port target RAM
    typedef enum logic {
        FEAT,
        PARAM
    } fc_mem_sel_e;

    // Four int8 lanes, lane 0 in the low byte
    typedef logic [`FC_LANES-1:0][7:0] fc_word_t;

    typedef logic signed [`FC_ACC_W-1:0] fc_acc_t;
    typedef logic signed [7:0]           fc_byte_t;
    typedef logic [`FC_CLASS_W-1:0]      fc_class_t;

endpackage

`default_nettype wire

//--- fc_ram.sv
`timescale 1ns/100ps
`default_nettype none

module fc_ram #(
    parameter int AW = 4,
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    input  logic          re,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- fc_mac.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module fc_mac
    import fc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     clear,
    input  logic     en,
    input  fc_word_t feat,
    input  fc_word_t weight,
    output fc_acc_t  acc
);

    logic signed [15:0] prod [`FC_LANES];
    logic signed [16:0] sum_lo;
    logic signed [16:0] sum_hi;
    logic signed [17:0] sum_all;

    // Lane products, both operands signed int8
    always_comb begin
        for (int i = 0; i < `FC_LANES; i++) begin
            prod[i] = fc_byte_t'(feat[i]) * fc_byte_t'(weight[i]);
        end
    end

    // Two-level adder tree
    assign sum_lo  = prod[0] + prod[1];
    assign sum_hi  = prod[2] + prod[3];
    assign sum_all = sum_lo + sum_hi;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (clear) begin
            // First word of a neuron replaces the old sum
            acc <= en ? fc_acc_t'(sum_all) : '0;
        end else if (en) begin
            acc <= acc + sum_all;
        end
    end

endmodule

`default_nettype wire

//--- fc_requant.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module fc_requant
    import fc_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     en,
    input  logic     relu,
    input  fc_acc_t  acc,
    input  fc_word_t bias,
    output fc_byte_t rq_byte
);

    logic signed [15:0]        bias16;
    logic signed [`FC_ACC_W:0] biased;
    logic signed [`FC_ACC_W:0] shifted;
    fc_byte_t                  sat;

    // Bias sits in the low half of its word
    assign bias16  = bias[1:0];
    assign biased  = acc + bias16;
    assign shifted = biased >>> `FC_SHIFT;

    always_comb begin
        if (shifted > 127) begin
            sat = 8'sd127;
        end else if (shifted < -128) begin
            sat = 8'sh80;
        end else begin
            sat = shifted[7:0];
        end
        // Hidden layer clamps negatives
        if (relu && sat[7]) begin
            sat = '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rq_byte <= '0;
        end else if (en) begin
            rq_byte <= sat;
        end
    end

endmodule

`default_nettype wire

//--- fc_argmax.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module fc_argmax
    import fc_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      max_clear,
    input  logic      score_en,
    input  fc_byte_t  score,
    input  fc_class_t score_idx,
    output fc_class_t class_id
);

    localparam fc_byte_t BYTE_MIN = 8'sh80;

    fc_byte_t  max_q;
    fc_class_t idx_q;
    logic      have_max_q;
    logic      take;
    fc_class_t best_idx;
    logic      last_score;

    // Strict compare, so a tie keeps the lower index
    assign take       = !have_max_q || (score > max_q);
    assign best_idx   = take ? score_idx : idx_q;
    assign last_score = score_idx == fc_class_t'(`FC_N_OUT - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            max_q      <= BYTE_MIN;
            idx_q      <= '0;
            have_max_q <= 1'b0;
            class_id   <= '0;
        end else if (max_clear) begin
            max_q      <= BYTE_MIN;
            have_max_q <= 1'b0;
        end else if (score_en) begin
            if (take) begin
                max_q <= score;
                idx_q <= score_idx;
            end
            have_max_q <= 1'b1;
            // Result only moves once the last class is in
            if (last_score) begin
                class_id <= best_idx;
            end
        end
    end

endmodule

`default_nettype wire

//--- fc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module fc_sequencer
    import fc_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start_req,
    output logic                    start_ack,
    output logic                    feat_re,
    output logic [`FC_FEAT_AW-1:0]  feat_raddr,
    output logic                    feat_we,
    output logic [`FC_FEAT_AW-1:0]  feat_waddr,
    output fc_word_t                feat_wdata,
    output logic                    param_re,
    output logic [`FC_PARAM_AW-1:0] param_raddr,
    output logic                    mac_clear,
    output logic                    mac_en,
    output logic                    rq_en,
    output logic                    relu,
    input  fc_byte_t                rq_byte,
    output logic                    score_en,
    output fc_class_t               score_idx,
    output logic                    max_clear
);

    localparam int NW0  = `FC_N_IN / `FC_LANES;
    localparam int NW1  = `FC_N_HID / `FC_LANES;
    localparam int NMAX = (`FC_N_HID > `FC_N_OUT) ? `FC_N_HID : `FC_N_OUT;
    localparam int WC_W = $clog2(NW0 + 1);
    localparam int NC_W = $clog2(NMAX + 1);
    localparam int LW   = $clog2(`FC_LANES);
    localparam int FAW  = `FC_FEAT_AW;
    localparam int PAW  = `FC_PARAM_AW;

    fc_state_e       state_q;
    logic            layer_q;
    logic [NC_W-1:0] n_q;
    logic [WC_W-1:0] w_q;
    logic [LW-1:0]   lane;
    fc_word_t        pack_q;
    fc_word_t        pack_next;

    // Per-layer geometry
    int nw;
    int feat_base;
    int w_base;
    int b_base;
    int n_last;

    always_comb begin
        nw        = layer_q ? NW1 : NW0;
        feat_base = layer_q ? `FC_HID_BASE : `FC_IN_BASE;
        w_base    = layer_q ? `FC_W1_BASE : `FC_W0_BASE;
        b_base    = layer_q ? `FC_B1_BASE : `FC_B0_BASE;
        n_last    = layer_q ? `FC_N_OUT - 1 : `FC_N_HID - 1;
    end

    // Hidden byte goes into its lane of the write-back word
    assign lane = n_q[LW-1:0];

    always_comb begin
        pack_next       = pack_q;
        pack_next[lane] = rq_byte;
    end

    // Paired reads in MAC, bias read on the first BIAS cycle
    assign feat_re     = state_q == MAC;
    assign feat_raddr  = FAW'(feat_base + int'(w_q));
    assign param_re    = (state_q == MAC) || (state_q == BIAS && w_q == '0);
    assign param_raddr = (state_q == BIAS) ? PAW'(b_base + int'(n_q))
                                           : PAW'(w_base + int'(n_q) * nw + int'(w_q));

    // Write-back once the last lane of a word is filled
    assign feat_we    = (state_q == STORE) && !layer_q && (lane == LW'(`FC_LANES - 1));
    assign feat_waddr = FAW'(`FC_HID_BASE + (int'(n_q) >> LW));
    assign feat_wdata = pack_next;

    assign relu      = !layer_q;
    assign score_en  = (state_q == STORE) && layer_q;
    assign score_idx = fc_class_t'(n_q);
    assign max_clear = (state_q == IDLE) && start_req;
    assign start_ack = state_q == DONE;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= IDLE;
            layer_q   <= 1'b0;
            n_q       <= '0;
            w_q       <= '0;
            mac_en    <= 1'b0;
            mac_clear <= 1'b0;
            rq_en     <= 1'b0;
        end else begin
            // MAC and requant strobes trail the reads by one cycle
            mac_en    <= state_q == MAC;
            mac_clear <= (state_q == MAC) && (w_q == '0);
            rq_en     <= (state_q == BIAS) && (w_q == '0);
            case (state_q)
                IDLE: begin
                    if (start_req) begin
                        state_q <= MAC;
                        layer_q <= 1'b0;
                        n_q     <= '0;
                        w_q     <= '0;
                    end
                end
                MAC: begin
                    if (int'(w_q) == nw - 1) begin
                        w_q     <= '0;
                        state_q <= BIAS;
                    end else begin
                        w_q <= w_q + 1'b1;
                    end
                end
                BIAS: begin
                    // Second cycle waits for the final sum and bias
                    if (w_q == '0) begin
                        w_q <= w_q + 1'b1;
                    end else begin
                        w_q     <= '0;
                        state_q <= STORE;
                    end
                end
                STORE: begin
                    if (int'(n_q) == n_last) begin
                        n_q <= '0;
                        if (!layer_q) begin
                            layer_q <= 1'b1;
                            state_q <= MAC;
                        end else begin
                            state_q <= DONE;
                        end
                    end else begin
                        n_q     <= n_q + 1'b1;
                        state_q <= MAC;
                    end
                end
                DONE: begin
                    if (!start_req) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == STORE && !layer_q) begin
            pack_q <= pack_next;
        end
    end

endmodule

`default_nettype wire

//--- fc_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module fc_top
    import fc_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    load_en,
    input  fc_mem_sel_e             load_sel,
    input  logic [`FC_PARAM_AW-1:0] load_addr,
    input  fc_word_t                load_data,
    input  logic                    start_req,
    output logic                    start_ack,
    output fc_class_t               class_id
);

    logic                    load_ok;
    logic                    feat_re;
    logic [`FC_FEAT_AW-1:0]  feat_raddr;
    logic                    seq_feat_we;
    logic [`FC_FEAT_AW-1:0]  seq_feat_waddr;
    fc_word_t                seq_feat_wdata;
    logic                    feat_we;
    logic [`FC_FEAT_AW-1:0]  feat_waddr;
    fc_word_t                feat_wdata;
    fc_word_t                feat_rdata;
    logic                    param_re;
    logic [`FC_PARAM_AW-1:0] param_raddr;
    logic                    param_we;
    fc_word_t                param_rdata;
    logic                    mac_clear;
    logic                    mac_en;
    fc_acc_t                 acc;
    logic                    rq_en;
    logic                    relu;
    fc_byte_t                rq_byte;
    logic                    score_en;
    fc_class_t               score_idx;
    logic                    max_clear;

    // Host writes only land while no inference is in progress
    assign load_ok = load_en && !start_req && !start_ack;

    assign feat_we    = load_ok ? (load_sel == FEAT) : seq_feat_we;
    assign feat_waddr = load_ok ? load_addr[`FC_FEAT_AW-1:0] : seq_feat_waddr;
    assign feat_wdata = load_ok ? load_data : seq_feat_wdata;
    assign param_we   = load_ok && (load_sel == PARAM);

    // Input features and hidden results
    fc_ram #(.AW(`FC_FEAT_AW), .DW(`FC_WORD_W)) feat_ram_i (
        .clk   (clk),
        .we    (feat_we),
        .waddr (feat_waddr),
        .wdata (feat_wdata),
        .re    (feat_re),
        .raddr (feat_raddr),
        .rdata (feat_rdata)
    );

    // Weights and biases
    fc_ram #(.AW(`FC_PARAM_AW), .DW(`FC_WORD_W)) param_ram_i (
        .clk   (clk),
        .we    (param_we),
        .waddr (load_addr),
        .wdata (load_data),
        .re    (param_re),
        .raddr (param_raddr),
        .rdata (param_rdata)
    );

    fc_mac mac_i (
        .clk    (clk),
        .rstn   (rstn),
        .clear  (mac_clear),
        .en     (mac_en),
        .feat   (feat_rdata),
        .weight (param_rdata),
        .acc    (acc)
    );

    fc_requant requant_i (
        .clk     (clk),
        .rstn    (rstn),
        .en      (rq_en),
        .relu    (relu),
        .acc     (acc),
        .bias    (param_rdata),
        .rq_byte (rq_byte)
    );

    fc_argmax argmax_i (
        .clk       (clk),
        .rstn      (rstn),
        .max_clear (max_clear),
        .score_en  (score_en),
        .score     (rq_byte),
        .score_idx (score_idx),
        .class_id  (class_id)
    );

    fc_sequencer sequencer_i (
        .clk         (clk),
        .rstn        (rstn),
        .start_req   (start_req),
        .start_ack   (start_ack),
        .feat_re     (feat_re),
        .feat_raddr  (feat_raddr),
        .feat_we     (seq_feat_we),
        .feat_waddr  (seq_feat_waddr),
        .feat_wdata  (seq_feat_wdata),
        .param_re    (param_re),
        .param_raddr (param_raddr),
        .mac_clear   (mac_clear),
        .mac_en      (mac_en),
        .rq_en       (rq_en),
        .relu        (relu),
        .rq_byte     (rq_byte),
        .score_en    (score_en),
        .score_idx   (score_idx),
        .max_clear   (max_clear)
    );

endmodule

`default_nettype wire

//--- fc_chk.sv
`timescale 1ns/100ps
`default_nettype none

module fc_chk
    import fc_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      load_en,
    input  logic      start_req,
    input  logic      start_ack,
    input  fc_class_t class_id
);

    // Failed assertion count
    int fail_cnt = 0;

    // Ack only answers a pending request
    ack_needs_req_a: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(start_ack) |-> start_req
    ) else begin
        fail_cnt++;
        $error("start_ack rose while start_req was low");
    end

    // Four-phase return to zero
    ack_falls_a: assert property (
        @(posedge clk) disable iff (!rstn)
        $fell(start_req) |-> ##[0:2] !start_ack
    ) else begin
        fail_cnt++;
        $error("start_ack stayed high after start_req dropped");
    end

    // Host loads only while the engine is idle
    load_idle_a: assert property (
        @(posedge clk) disable iff (!rstn)
        load_en |-> (!start_req && !start_ack)
    ) else begin
        fail_cnt++;
        $error("load_en high during an inference");
    end

    // Result holds for the whole ack phase
    class_stable_a: assert property (
        @(posedge clk) disable iff (!rstn)
        (start_ack && $past(start_ack)) |-> $stable(class_id)
    ) else begin
        fail_cnt++;
        $error("class_id changed while start_ack was high");
    end

endmodule

`default_nettype wire

//--- tb_fc.sv
`timescale 1ns/100ps
`default_nettype none
`include "fc_defines.svh"

module tb_fc
    import fc_pkg::*;
();

    localparam int N_PARAM         = 28;
    localparam int N_TESTS         = 6;
    localparam int N_FEAT_WORDS    = `FC_N_IN / `FC_LANES;
    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_TEST = 400;
    localparam int LOAD_CYCLES     = RESET_CYCLES + 4 + N_PARAM + N_TESTS * (N_FEAT_WORDS + 1);
    localparam int MAX_CYCLES      = N_TESTS * CYCLES_PER_TEST + LOAD_CYCLES;
    localparam int PAW             = `FC_PARAM_AW;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    load_en;
    fc_mem_sel_e             load_sel;
    logic [`FC_PARAM_AW-1:0] load_addr;
    fc_word_t                load_data;
    logic                    start_req;
    logic                    start_ack;
    fc_class_t               class_id;

    integer    seed;
    int        cycle_cnt = 0;
    fc_word_t  param_words [N_PARAM];
    fc_word_t  feat_words [N_TESTS][N_FEAT_WORDS];
    fc_class_t exp_class [N_TESTS];

    always #5 clk = ~clk;

    fc_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .start_req (start_req),
        .start_ack (start_ack),
        .class_id  (class_id)
    );

    bind fc_top fc_chk chk_i (
        .clk       (clk),
        .rstn      (rstn),
        .load_en   (load_en),
        .start_req (start_req),
        .start_ack (start_ack),
        .class_id  (class_id)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_class(input fc_class_t exp, input fc_class_t act, input string what);
        if (act !== exp) begin
            abort_run($sformatf("Error: class_id expected %h got %h (%s)", exp, act, what));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h got %h", name, exp, act));
        end
    endtask

    // Values in file order, comment lines skipped
    task automatic read_golden();
        int          fd;
        int          code;
        int          base;
        string       line;
        logic [31:0] v;
        fc_word_t    vals [$];
        fd = $fopen("fc_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open fc_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && !(line.len() >= 2 && line.substr(0, 1) == "//")) begin
                if ($sscanf(line, "%h", v) == 1) begin
                    vals.push_back(v);
                end
            end
        end
        $fclose(fd);
        if (vals.size() != N_PARAM + N_TESTS * (N_FEAT_WORDS + 1)) begin
            abort_run("The golden file does not hold the expected number of values");
        end
        for (int i = 0; i < N_PARAM; i++) begin
            param_words[i] = vals[i];
        end
        for (int t = 0; t < N_TESTS; t++) begin
            base = N_PARAM + t * (N_FEAT_WORDS + 1);
            for (int w = 0; w < N_FEAT_WORDS; w++) begin
                feat_words[t][w] = vals[base + w];
            end
            exp_class[t] = fc_class_t'(vals[base + N_FEAT_WORDS]);
        end
    endtask

    task automatic load_word(input fc_mem_sel_e sel, input int addr, input fc_word_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_sel  <= sel;
        load_addr <= PAW'(addr);
        load_data <= data;
    endtask

    task automatic end_load();
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_ack(input logic level, input string why);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > CYCLES_PER_TEST) begin
                abort_run(why);
            end
        end while (start_ack !== level);
    endtask

    task automatic run_inference(input int t);
        @(posedge clk);
        start_req <= 1'b1;
        wait_ack(1'b1, $sformatf("start_ack never rose in test %0d", t));
        check_class(exp_class[t], class_id, $sformatf("test %0d", t));
        start_req <= 1'b0;
        wait_ack(1'b0, $sformatf("start_ack never fell after start_req dropped in test %0d", t));
    endtask

    // Run limit and bound assertion watch
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
        if (dut_i.chk_i.fail_cnt != 0) begin
            abort_run("A handshake or load rule assertion failed");
        end
    end

    initial begin
        int gap;
        seed      = 32'h6791;
        rstn      = 1'b0;
        load_en   = 1'b0;
        load_sel  = FEAT;
        load_addr = '0;
        load_data = '0;
        start_req = 1'b0;
        read_golden();
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        check_flag("start_ack", 1'b0, start_ack);
        check_class('0, class_id, "after reset");

        // Parameters stay loaded for every test
        for (int i = 0; i < N_PARAM; i++) begin
            load_word(PARAM, i, param_words[i]);
        end
        end_load();

        for (int t = 0; t < N_TESTS; t++) begin
            for (int w = 0; w < N_FEAT_WORDS; w++) begin
                load_word(FEAT, `FC_IN_BASE + w, feat_words[t][w]);
            end
            end_load();
            run_inference(t);
            gap = $unsigned($random(seed)) % 8;
            repeat (gap) @(posedge clk);
        end

        @(posedge clk);
        if (dut_i.chk_i.fail_cnt != 0) begin
            abort_run("A handshake or load rule assertion failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
fc_pkg.sv
fc_ram.sv
fc_mac.sv
fc_requant.sv
fc_argmax.sv
fc_sequencer.sv
fc_top.sv
fc_chk.sv
tb_fc.sv

//--- fc_golden.txt
// One hex word per line. First 28 parameter words in RAM address order,
// then per test 4 feature words (word 0 first) and the expected class
40404040 // w0 n0 word0
00000000
00000000
00000000
000000C0 // w0 n1 word0
40404040
00000000
00000000
00000000
00000000
40404040 // w0 n2 word2
00000000
00000000
00000000
00000000
40404040 // w0 n3 word3
00000000 // b0 n0
00000000
0000FFC0
00000080
0000E040 // w1 n0
00E04000
E0400000
400000E0
00000000 // b1 n0
0000FFC0
00000000
00000000
05050505 // test 0 basic
0A0A0A0A
01010101
00000000
1
7F7F7F7F // test 1 hidden saturation
7F7F7F7F
7F7F7F7F
00000000
2
F6F6F6F6 // test 2 tie between class 1 and 3
0B0A0A0A
00000000
0C0C0C0C
1
03FD02FE // test 3 mixed signs
00000001
10F00808
202020E0
3
1E1E1E1E // test 4 negative hidden clipped
14141414
05050505
81818181
0
00000000 // test 5 small values
00000000
02020202
00000000
2
